/* src/ppu_pkg.sv */
// --------------------
// shared types, register map, LCD modes, fetch phases
// and dot/line timing constants of the background PPU
// --------------------

package ppu_pkg;

	// --------------------
	// data types
	// --------------------

	// cpu bus and vram data byte
	typedef logic [7:0] byte_t;

	// 8 KB vram byte address
	typedef logic [12:0] vram_addr_t;

	// dmg grey level, 0 is lightest
	typedef logic [1:0] shade_t;

	// stat mode field, values as seen by the cpu
	typedef enum logic [1:0] {
		MODE_HBLANK   = 2'd0,
		MODE_VBLANK   = 2'd1,
		MODE_OAM      = 2'd2,
		MODE_TRANSFER = 2'd3
	} lcd_mode_e;

	// register offsets inside the 0xff00 page
	typedef enum logic [7:0] {
		REG_LCDC = 8'h40,
		REG_STAT = 8'h41,
		REG_SCY  = 8'h42,
		REG_SCX  = 8'h43,
		REG_LY   = 8'h44,
		REG_LYC  = 8'h45,
		REG_BGP  = 8'h47
	} reg_addr_e;

	// phases of one 8-dot tile slot, two dots each
	typedef enum logic [1:0] {
		FETCH_MAP,
		FETCH_DATA0,
		FETCH_DATA1,
		FETCH_LOAD
	} fetch_step_e;

	// --------------------
	// timing constants
	// --------------------

	localparam logic [8:0] H_LAST       = 9'd455;
	localparam logic [8:0] V_LAST       = 9'd153;
	localparam logic [8:0] V_VISIBLE    = 9'd144;
	localparam logic [8:0] OAM_LEN      = 9'd80;
	// first hblank dot, mode 3 has a fixed length
	localparam logic [8:0] TRANSFER_END = 9'd252;
	localparam logic [8:0] PIX_START    = 9'd88;
	localparam logic [8:0] PIX_COUNT    = 9'd160;
	// 20 visible tiles plus one prefetch
	localparam logic [8:0] TILE_SLOTS   = 9'd21;

	// background tile maps, selected by lcdc bit 3
	localparam vram_addr_t MAP_BASE_0 = 13'h1800;
	localparam vram_addr_t MAP_BASE_1 = 13'h1C00;

	localparam logic [8:0] BGP_RESET = 9'h0FC;

endpackage

/* src/ppu_cfg_if.sv */
// --------------------
// register settings and timing status shared by regs, timing and fetcher
// --------------------

interface ppu_cfg_if;
	import ppu_pkg::*;

	// lcdc fields
	logic      lcd_on;
	logic      bg_map_sel;
	logic      tile_data_sel;
	logic      bg_enable;

	// scroll, compare and palette
	byte_t     scy;
	byte_t     scx;
	byte_t     lyc;
	byte_t     bgp;

	// stat bits 6:3, msb is the ly=lyc source
	logic [3:0] stat_int_en;

	// status from the timing generator
	byte_t     ly;
	lcd_mode_e mode;
	logic      lyc_match;
	logic      line_start;
	logic      transfer;

	modport regs (
		output lcd_on, bg_map_sel, tile_data_sel, bg_enable,
		output scy, scx, lyc, bgp, stat_int_en,
		input  ly, mode, lyc_match
	);

	modport timing (
		input  lcd_on, lyc, stat_int_en,
		output ly, mode, lyc_match, line_start, transfer
	);

	modport fetch (
		input  lcd_on, bg_map_sel, tile_data_sel, bg_enable,
		input  scy, scx, bgp,
		input  ly, line_start, transfer
	);

endinterface

/* src/ppu_regs.sv */
// --------------------
// cpu register block: lcdc, stat, scy, scx, ly, lyc, bgp
// writes on the select strobe, read-back mux is combinational
// --------------------

module ppu_regs (
	input  logic           clk_reg,
	input  logic           reset,

	// cpu bus
	input  logic           cpu_sel_reg,
	input  logic           cpu_wr,
	input  ppu_pkg::byte_t cpu_addr,
	input  ppu_pkg::byte_t cpu_di,
	output ppu_pkg::byte_t cpu_do,

	ppu_cfg_if.regs        cfg
);
	import ppu_pkg::*;

	// full lcdc byte kept for read-back, only 4 bits are used
	byte_t      lcdc;
	// stat bits 6:3, the rest of stat is status
	logic [3:0] stat_en;
	byte_t      scy;
	byte_t      scx;
	byte_t      lyc;
	byte_t      bgp;

	logic       wr_en;
	reg_addr_e  wr_reg;

	assign wr_en  = cpu_sel_reg && cpu_wr;
	assign wr_reg = reg_addr_e'(cpu_addr);

	// --------------------
	// register writes
	// --------------------

	always_ff @(posedge clk_reg) begin
		if (reset) begin
			// lcd starts switched off
			lcdc    <= 8'h00;
			stat_en <= 4'h0;
			scy     <= 8'h00;
			scx     <= 8'h00;
			lyc     <= 8'h00;
			bgp     <= BGP_RESET[7:0];
		end else if (wr_en) begin
			case (wr_reg)
				REG_LCDC: lcdc <= cpu_di;
				REG_STAT: stat_en <= cpu_di[6:3];
				REG_SCY:  scy <= cpu_di;
				REG_SCX:  scx <= cpu_di;
				// ly is read only, a write does nothing
				REG_LY:   lcdc <= lcdc;
				REG_LYC:  lyc <= cpu_di;
				REG_BGP:  bgp <= cpu_di;
				default:  lcdc <= lcdc;
			endcase
		end
	end

	// --------------------
	// read-back
	// --------------------

	always_comb begin
		case (reg_addr_e'(cpu_addr))
			REG_LCDC: cpu_do = lcdc;
			// bit 7 always reads as one
			REG_STAT: cpu_do = {1'b1, stat_en, cfg.lyc_match, cfg.mode};
			REG_SCY:  cpu_do = scy;
			REG_SCX:  cpu_do = scx;
			REG_LY:   cpu_do = cfg.ly;
			REG_LYC:  cpu_do = lyc;
			REG_BGP:  cpu_do = bgp;
			// open bus on anything unmapped
			default:  cpu_do = 8'hFF;
		endcase
	end

	// --------------------
	// settings to timing and fetcher
	// --------------------

	// lcdc bit 7: display on
	assign cfg.lcd_on        = lcdc[7];
	// lcdc bit 3: bg map at 0x1c00 when set
	assign cfg.bg_map_sel    = lcdc[3];
	// lcdc bit 4: unsigned tile numbers from 0x0000 when set
	assign cfg.tile_data_sel = lcdc[4];
	// lcdc bit 0: bg off gives shade 0
	assign cfg.bg_enable     = lcdc[0];

	assign cfg.scy         = scy;
	assign cfg.scx         = scx;
	assign cfg.lyc         = lyc;
	assign cfg.bgp         = bgp;
	assign cfg.stat_int_en = stat_en;

endmodule

/* src/lcd_timing.sv */
// --------------------
// dot and line counters, lcd mode, ly=lyc compare and stat irq
// --------------------

module lcd_timing (
	input  logic      clk_reg,
	input  logic      reset,
	output logic      irq,
	ppu_cfg_if.timing cfg
);
	import ppu_pkg::*;

	// dot inside line, 0..455
	logic [8:0] h_cnt;
	// line inside frame, 0..153
	byte_t      v_cnt;
	logic       visible;
	logic       lyc_match;
	lcd_mode_e  mode_c;
	logic       irq_set;

	// --------------------
	// counters
	// --------------------

	// held at 0 while the display is off
	always_ff @(posedge clk_reg) begin
		if (reset || !cfg.lcd_on) begin
			h_cnt <= 9'd0;
			v_cnt <= 8'd0;
		end else if (h_cnt == H_LAST) begin
			h_cnt <= 9'd0;
			if (v_cnt == V_LAST[7:0])
				v_cnt <= 8'd0;
			else
				v_cnt <= v_cnt + 8'd1;
		end else begin
			h_cnt <= h_cnt + 9'd1;
		end
	end

	assign visible   = v_cnt < V_VISIBLE[7:0];
	assign lyc_match = v_cnt == cfg.lyc;

	// mode 2 -> 3 -> 0 on visible lines, mode 1 below them
	always_comb begin
		if (!cfg.lcd_on)
			mode_c = MODE_HBLANK;
		else if (!visible)
			mode_c = MODE_VBLANK;
		else if (h_cnt < OAM_LEN)
			mode_c = MODE_OAM;
		else if (h_cnt < TRANSFER_END)
			mode_c = MODE_TRANSFER;
		else
			mode_c = MODE_HBLANK;
	end

	assign cfg.ly        = v_cnt;
	assign cfg.mode      = mode_c;
	assign cfg.lyc_match = lyc_match;
	// last oam dot, fetcher latches its scroll values here
	assign cfg.line_start = cfg.lcd_on && visible && (h_cnt == OAM_LEN - 9'd1);
	assign cfg.transfer   = cfg.lcd_on && visible &&
		(h_cnt >= OAM_LEN) && (h_cnt < TRANSFER_END);

	// --------------------
	// stat interrupt
	// --------------------

	// en[3] lyc, en[2] oam, en[1] vblank, en[0] hblank
	always_comb begin
		irq_set = 1'b0;
		if (cfg.lcd_on) begin
			if (cfg.stat_int_en[3] && (h_cnt == 9'd1) && lyc_match)
				irq_set = 1'b1;
			if (cfg.stat_int_en[2] && (h_cnt == 9'd0) && visible)
				irq_set = 1'b1;
			// end of last visible line
			if (cfg.stat_int_en[1] && (h_cnt == H_LAST) &&
					(v_cnt == V_VISIBLE[7:0] - 8'd1))
				irq_set = 1'b1;
			if (cfg.stat_int_en[0] && (h_cnt == TRANSFER_END) && visible)
				irq_set = 1'b1;
		end
	end

	// one cycle pulse, a cycle after the condition
	always_ff @(posedge clk_reg) begin
		if (reset)
			irq <= 1'b0;
		else
			irq <= irq_set;
	end

endmodule

/* src/bg_fetcher.sv */
// --------------------
// background tile fetch from vram, pixel shifters and bgp lookup
// --------------------

module bg_fetcher (
	input  logic                clk_reg,
	input  logic                reset,
	ppu_cfg_if.fetch            cfg,

	// vram read port, data one cycle after the strobe
	output logic                vram_rd,
	output ppu_pkg::vram_addr_t vram_addr,
	input  ppu_pkg::byte_t      vram_data,

	// lcd pixel stream
	output logic                lcd_clkena,
	output ppu_pkg::shade_t     lcd_data
);
	import ppu_pkg::*;

	// scroll values frozen for the line
	byte_t       scy_r;
	logic [4:0]  scx_tile;

	// slot sequencer
	logic [4:0]  slot;
	fetch_step_e step;
	logic        half;
	logic        fetch_active;

	logic [7:0]  row;
	logic [4:0]  map_col;
	vram_addr_t  map_base;
	logic        tile_a12;

	byte_t       tile_num;
	byte_t       tile_d0;
	byte_t       tile_d1;
	byte_t       shift0;
	byte_t       shift1;

	logic        pix_start;
	logic        pix_on;
	byte_t       pix_cnt;
	logic [1:0]  color_idx;

	// --------------------
	// slot sequencer
	// --------------------

	assign fetch_active = cfg.transfer && ({4'd0, slot} < TILE_SLOTS);

	// step moves on every second dot, slot after the load phase
	always_ff @(posedge clk_reg) begin
		if (reset || cfg.line_start) begin
			slot <= 5'd0;
			step <= FETCH_MAP;
			half <= 1'b0;
		end else if (fetch_active) begin
			half <= ~half;
			if (half) begin
				case (step)
					FETCH_MAP:   step <= FETCH_DATA0;
					FETCH_DATA0: step <= FETCH_DATA1;
					FETCH_DATA1: step <= FETCH_LOAD;
					FETCH_LOAD: begin
						step <= FETCH_MAP;
						slot <= slot + 5'd1;
					end
				endcase
			end
		end
	end

	always_ff @(posedge clk_reg) begin
		if (cfg.line_start) begin
			scy_r    <= cfg.scy;
			// fine scroll bits are not used
			scx_tile <= cfg.scx[7:3];
		end
	end

	// --------------------
	// vram addressing
	// --------------------

	assign row      = cfg.ly + scy_r;
	// map column wraps inside the 32 tile row
	assign map_col  = scx_tile + slot;
	assign map_base = cfg.bg_map_sel ? MAP_BASE_1 : MAP_BASE_0;
	// signed tile numbers around 0x1000 when lcdc bit 4 is clear
	assign tile_a12 = !cfg.tile_data_sel && !tile_num[7];

	// strobe on the first dot of each read phase
	always_comb begin
		vram_rd   = 1'b0;
		vram_addr = map_base + vram_addr_t'({row[7:3], map_col});
		if (fetch_active && !half) begin
			case (step)
				FETCH_MAP:   vram_rd = 1'b1;
				FETCH_DATA0: begin
					vram_rd   = 1'b1;
					vram_addr = {tile_a12, tile_num, row[2:0], 1'b0};
				end
				FETCH_DATA1: begin
					vram_rd   = 1'b1;
					vram_addr = {tile_a12, tile_num, row[2:0], 1'b1};
				end
				default:     vram_rd = 1'b0;
			endcase
		end
	end

	// read data arrives on the second dot of the phase
	always_ff @(posedge clk_reg) begin
		if (fetch_active && half) begin
			case (step)
				FETCH_MAP:   tile_num <= vram_data;
				FETCH_DATA0: tile_d0 <= vram_data;
				FETCH_DATA1: tile_d1 <= vram_data;
				default:     tile_num <= tile_num;
			endcase
		end
	end

	// --------------------
	// pixel output
	// --------------------

	// load at the end of the slot, shift msb first otherwise
	always_ff @(posedge clk_reg) begin
		if (fetch_active && half && (step == FETCH_LOAD)) begin
			shift0 <= tile_d0;
			shift1 <= tile_d1;
		end else begin
			shift0 <= {shift0[6:0], 1'b0};
			shift1 <= {shift1[6:0], 1'b0};
		end
	end

	// slot 0 load coincides with the dot before PIX_START
	assign pix_start = fetch_active &&
		({slot, step, half} == 8'(PIX_START - OAM_LEN - 9'd1));

	// fixed 160 pixel window per line
	always_ff @(posedge clk_reg) begin
		if (reset || !cfg.lcd_on) begin
			pix_on  <= 1'b0;
			pix_cnt <= 8'd0;
		end else if (pix_start) begin
			pix_on  <= 1'b1;
			pix_cnt <= 8'd0;
		end else if (pix_on) begin
			if (pix_cnt == 8'(PIX_COUNT - 9'd1))
				pix_on <= 1'b0;
			pix_cnt <= pix_cnt + 8'd1;
		end
	end

	assign color_idx  = {shift1[7], shift0[7]};
	assign lcd_clkena = pix_on;
	// bgp holds four 2-bit shades indexed by colour
	assign lcd_data   = cfg.bg_enable ? cfg.bgp[{color_idx, 1'b0} +: 2] : 2'b00;

endmodule

/* src/ppu_top.sv */
// --------------------
// background ppu top: register block, lcd timing, bg fetcher
// --------------------

module ppu_top (
	input  logic                clk_reg,
	input  logic                reset,

	// cpu register bus
	input  logic                cpu_sel_reg,
	input  logic                cpu_wr,
	input  ppu_pkg::byte_t      cpu_addr,
	input  ppu_pkg::byte_t      cpu_di,
	output ppu_pkg::byte_t      cpu_do,

	// lcd side
	output logic                lcd_on,
	output logic                lcd_clkena,
	output ppu_pkg::shade_t     lcd_data,
	output logic                irq,
	output ppu_pkg::lcd_mode_e  mode,

	// external vram
	output logic                vram_rd,
	output ppu_pkg::vram_addr_t vram_addr,
	input  ppu_pkg::byte_t      vram_data
);

	// settings and status between the three blocks
	ppu_cfg_if cfg ();

	ppu_regs u_regs (
		.clk_reg     (clk_reg),
		.reset       (reset),
		.cpu_sel_reg (cpu_sel_reg),
		.cpu_wr      (cpu_wr),
		.cpu_addr    (cpu_addr),
		.cpu_di      (cpu_di),
		.cpu_do      (cpu_do),
		.cfg         (cfg)
	);

	lcd_timing u_timing (
		.clk_reg (clk_reg),
		.reset   (reset),
		.irq     (irq),
		.cfg     (cfg)
	);

	bg_fetcher u_fetcher (
		.clk_reg    (clk_reg),
		.reset      (reset),
		.cfg        (cfg),
		.vram_rd    (vram_rd),
		.vram_addr  (vram_addr),
		.vram_data  (vram_data),
		.lcd_clkena (lcd_clkena),
		.lcd_data   (lcd_data)
	);

	// status also goes out to the lcd and vram arbiter
	assign lcd_on = cfg.lcd_on;
	assign mode   = cfg.mode;

endmodule

/* testbench/tb_checks.svh */
// --------------------
// lcg, test counters and compare tasks for tb_ppu
// --------------------

`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

// lcg state, fixed seed
logic [31:0] lcg_state = 32'd35235;

string test_name = "";
int    tests_run = 0;
int    tests_failed = 0;
int    checks_total = 0;
int    errors_total = 0;
int    test_checks = 0;
int    test_errors = 0;
// later error lines are counted but not printed
localparam int MAX_ERROR_LINES = 40;

// --------------------
// random numbers
// --------------------

function automatic logic [31:0] next_rand();
	lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
	return lcg_state;
endfunction

// middle bits, the low lcg bits repeat quickly
function automatic byte_t rand_byte();
	logic [31:0] r;
	r = next_rand();
	return r[23:16];
endfunction

// --------------------
// bookkeeping
// --------------------

task automatic begin_test(string name);
	test_name   = name;
	test_checks = 0;
	test_errors = 0;
endtask

task automatic end_test();
	tests_run++;
	checks_total += test_checks;
	if (test_errors == 0) begin
		$display("test %s: passed, %0d checks", test_name, test_checks);
	end else begin
		tests_failed++;
		$display("test %s: FAILED, %0d of %0d checks wrong", test_name, test_errors,
			test_checks);
	end
endtask

task automatic note_error(string msg);
	test_errors++;
	errors_total++;
	if (errors_total <= MAX_ERROR_LINES)
		$display("%s", msg);
	else if (errors_total == MAX_ERROR_LINES + 1)
		$display("more errors follow, their lines are not shown");
endtask

task automatic report_failure(string msg);
	test_checks++;
	note_error($sformatf("%s: %s", test_name, msg));
endtask

// --------------------
// compare tasks
// --------------------

task automatic check_byte(string what, byte_t expected, byte_t actual);
	test_checks++;
	if (actual !== expected)
		note_error($sformatf("Mismatch %s, %s: expected %02h, actual %02h",
			test_name, what, expected, actual));
endtask

task automatic check_mode(string what, lcd_mode_e expected, lcd_mode_e actual);
	test_checks++;
	if (actual !== expected)
		note_error($sformatf("Mismatch %s, %s: expected %s, actual %s",
			test_name, what, expected.name(), actual.name()));
endtask

task automatic check_shade(string what, shade_t expected, shade_t actual);
	test_checks++;
	if (actual !== expected)
		note_error($sformatf("Mismatch %s, %s: expected %0d, actual %0d",
			test_name, what, expected, actual));
endtask

task automatic check_count(string what, int expected, int actual);
	test_checks++;
	if (actual != expected)
		note_error($sformatf("Mismatch %s, %s: expected %0d, actual %0d",
			test_name, what, expected, actual));
endtask

`endif

/* testbench/tb_ppu.sv */
// --------------------
// testbench for ppu_top: vram model, frame model, random tests, watchdog
// --------------------

module tb_ppu;
	import ppu_pkg::*;

	// frame geometry as plain ints for the model
	localparam int LINE_DOTS  = int'(H_LAST) + 1;
	localparam int FRAME_DOTS = LINE_DOTS * (int'(V_LAST) + 1);
	localparam int VIS_LINES  = int'(V_VISIBLE);
	localparam int OAM_DOTS   = int'(OAM_LEN);
	localparam int XFER_END   = int'(TRANSFER_END);
	localparam int PIX_FIRST  = int'(PIX_START);
	localparam int PIX_LINE   = int'(PIX_COUNT);
	// one frame for modes, two each for irq and pixels
	localparam int FRAMES_RUN = 5;
	localparam longint WATCHDOG_TIME = longint'(FRAMES_RUN + 2) * FRAME_DOTS * 20;

	logic       clk_reg;
	logic       reset;
	logic       cpu_sel_reg;
	logic       cpu_wr;
	byte_t      cpu_addr;
	byte_t      cpu_di;
	byte_t      cpu_do;
	logic       lcd_on;
	logic       lcd_clkena;
	shade_t     lcd_data;
	logic       irq;
	lcd_mode_e  mode;
	logic       vram_rd;
	vram_addr_t vram_addr;
	byte_t      vram_data;

	// 8 KB background vram contents
	byte_t      vram_mem [0:8191];

	// read request as seen by the memory at the rising edge
	logic       vram_req;
	vram_addr_t vram_req_addr;

	`include "tb_checks.svh"

	ppu_top DUT (
		.clk_reg     (clk_reg),
		.reset       (reset),
		.cpu_sel_reg (cpu_sel_reg),
		.cpu_wr      (cpu_wr),
		.cpu_addr    (cpu_addr),
		.cpu_di      (cpu_di),
		.cpu_do      (cpu_do),
		.lcd_on      (lcd_on),
		.lcd_clkena  (lcd_clkena),
		.lcd_data    (lcd_data),
		.irq         (irq),
		.mode        (mode),
		.vram_rd     (vram_rd),
		.vram_addr   (vram_addr),
		.vram_data   (vram_data)
	);

	initial begin
		clk_reg = 1'b0;
		forever #10 clk_reg = ~clk_reg;
	end

	// strobe taken at the rising edge, data valid through the next cycle
	always @(posedge clk_reg) begin
		vram_req      <= vram_rd;
		vram_req_addr <= vram_addr;
	end

	always @(negedge clk_reg) begin
		if (vram_req)
			vram_data <= vram_mem[vram_req_addr];
	end

	initial begin
		#(WATCHDOG_TIME);
		$display("timeout: the tests did not finish within the expected frames");
		$display("Done: errors found");
		$finish;
	end

	// --------------------
	// frame model
	// --------------------

	function automatic lcd_mode_e model_mode(int h, int v);
		if (v >= VIS_LINES)
			return MODE_VBLANK;
		if (h < OAM_DOTS)
			return MODE_OAM;
		if (h < XFER_END)
			return MODE_TRANSFER;
		return MODE_HBLANK;
	endfunction

	// background pixel x on line y, straight from the vram array
	function automatic shade_t model_shade(int x, int y, byte_t scy, byte_t scx,
			byte_t bgp, byte_t lcdc);
		int    row;
		int    col;
		int    map_addr;
		int    data_addr;
		int    bit_pos;
		int    idx;
		byte_t tile;
		byte_t lo;
		byte_t hi;
		row      = (y + int'(scy)) % 256;
		col      = (int'(scx) / 8 + x / 8) % 32;
		map_addr = (lcdc[3] ? int'(MAP_BASE_1) : int'(MAP_BASE_0)) + (row / 8) * 32 + col;
		tile     = vram_mem[map_addr];
		data_addr = int'(tile) * 16 + (row % 8) * 2;
		// signed tile area sits 4 KB up for tile numbers below 0x80
		if (!lcdc[4] && !tile[7])
			data_addr += 'h1000;
		lo      = vram_mem[data_addr];
		hi      = vram_mem[data_addr + 1];
		bit_pos = 7 - x % 8;
		idx     = {hi[bit_pos], lo[bit_pos]};
		if (!lcdc[0])
			return 2'b00;
		return bgp[2 * idx +: 2];
	endfunction

	// --------------------
	// bus helpers
	// --------------------

	task automatic write_reg(byte_t addr, byte_t data);
		cpu_sel_reg = 1'b1;
		cpu_wr      = 1'b1;
		cpu_addr    = addr;
		cpu_di      = data;
		@(negedge clk_reg);
		cpu_sel_reg = 1'b0;
		cpu_wr      = 1'b0;
	endtask

	task automatic read_reg(byte_t addr, output byte_t data);
		cpu_addr = addr;
		@(negedge clk_reg);
		data = cpu_do;
	endtask

	task automatic switch_lcd_off();
		write_reg(REG_LCDC, 8'h00);
		// counters clear on the edge after lcd_on falls
		repeat (2) @(negedge clk_reg);
	endtask

	// --------------------
	// tests
	// --------------------

	task automatic reg_readback();
		byte_t val;
		byte_t data;
		byte_t rw_addr [5];
		byte_t bad_addr [3];
		rw_addr  = '{REG_LCDC, REG_SCY, REG_SCX, REG_LYC, REG_BGP};
		// 0x46 was oam dma, the others were never mapped
		bad_addr = '{8'h46, 8'h48, 8'h68};
		begin_test("register read-back");
		read_reg(REG_BGP, val);
		check_byte("bgp after reset", 8'hFC, val);
		repeat (4) begin
			foreach (rw_addr[i]) begin
				data = rand_byte();
				write_reg(rw_addr[i], data);
				read_reg(rw_addr[i], val);
				check_byte($sformatf("reg %02h", rw_addr[i]), data, val);
			end
		end
		switch_lcd_off();
		// ly follows the line counter, a cpu write must not disturb it
		write_reg(REG_LCDC, 8'h80);
		repeat (LINE_DOTS + 8) @(negedge clk_reg);
		write_reg(REG_LY, rand_byte());
		read_reg(REG_LY, val);
		check_byte("ly after write", 8'h01, val);
		foreach (bad_addr[i]) begin
			read_reg(bad_addr[i], val);
			check_byte($sformatf("unmapped %02h", bad_addr[i]), 8'hFF, val);
		end
		end_test();
	endtask

	task automatic lcd_off_outputs();
		int on_cnt;
		int ena_cnt;
		int rd_cnt;
		int irq_cnt;
		begin_test("lcd off");
		switch_lcd_off();
		// every stat source armed, ly=lyc holds all the time
		write_reg(REG_STAT, 8'h78);
		write_reg(REG_LYC, 8'h00);
		cpu_addr = REG_LY;
		on_cnt  = 0;
		ena_cnt = 0;
		rd_cnt  = 0;
		irq_cnt = 0;
		repeat (2 * LINE_DOTS) begin
			@(negedge clk_reg);
			check_byte("ly", 8'h00, cpu_do);
			check_mode("mode", MODE_HBLANK, mode);
			if (lcd_on)
				on_cnt++;
			if (lcd_clkena)
				ena_cnt++;
			if (vram_rd)
				rd_cnt++;
			if (irq)
				irq_cnt++;
		end
		check_count("lcd_on cycles", 0, on_cnt);
		check_count("lcd_clkena cycles", 0, ena_cnt);
		check_count("vram_rd cycles", 0, rd_cnt);
		check_count("irq cycles", 0, irq_cnt);
		end_test();
	endtask

	task automatic mode_schedule();
		byte_t      lyc;
		byte_t      r;
		logic [3:0] en;
		lcd_mode_e  exp_mode;
		int         h;
		int         v;
		int         on_cnt;
		lyc = byte_t'(rand_byte() % 154);
		r   = rand_byte();
		en  = r[6:3];
		begin_test("modes and ly");
		switch_lcd_off();
		write_reg(REG_STAT, {1'b0, en, 3'b000});
		write_reg(REG_LYC, lyc);
		// first sample below is dot 0 of line 0
		write_reg(REG_LCDC, 8'h91);
		on_cnt = 0;
		for (int d = 0; d < FRAME_DOTS; d++) begin
			h = d % LINE_DOTS;
			v = d / LINE_DOTS;
			exp_mode = model_mode(h, v);
			check_mode("mode", exp_mode, mode);
			if (lcd_on)
				on_cnt++;
			// ly and stat read on alternate dots
			if (d > 0) begin
				if (cpu_addr == REG_LY)
					check_byte("ly", byte_t'(v), cpu_do);
				else
					check_byte("stat", {1'b1, en, (v == int'(lyc)), exp_mode}, cpu_do);
			end
			cpu_addr = (d % 2 == 0) ? REG_LY : REG_STAT;
			@(negedge clk_reg);
		end
		check_count("lcd_on cycles", FRAME_DOTS, on_cnt);
		end_test();
	endtask

	task automatic irq_counts();
		byte_t      lyc;
		byte_t      r;
		logic [3:0] en;
		int         expected;
		int         pulses;
		// lyc above 153 now and then, that source stays silent then
		lyc = byte_t'(rand_byte() % 160);
		r   = rand_byte();
		en  = r[6:3];
		begin_test("stat irq");
		switch_lcd_off();
		write_reg(REG_STAT, {1'b0, en, 3'b000});
		write_reg(REG_LYC, lyc);
		write_reg(REG_LCDC, 8'h80);
		// the four sources never share a dot, so each gives its own pulse
		expected = 0;
		if (en[3] && lyc <= 8'd153)
			expected += 1;
		if (en[2])
			expected += VIS_LINES;
		if (en[1])
			expected += 1;
		if (en[0])
			expected += VIS_LINES;
		pulses = 0;
		repeat (FRAME_DOTS) begin
			if (irq)
				pulses++;
			@(negedge clk_reg);
		end
		check_count("irq pulses per frame", expected, pulses);
		end_test();
	endtask

	task automatic pixel_frame();
		byte_t scy;
		byte_t scx;
		byte_t bgp;
		byte_t lcdc;
		int    h;
		int    v;
		int    x;
		int    line_pix;
		scy  = rand_byte();
		scx  = rand_byte();
		bgp  = rand_byte();
		// random map select, tile data mode and bg enable
		lcdc = 8'h80 | (rand_byte() & 8'h19);
		begin_test("pixels");
		switch_lcd_off();
		write_reg(REG_SCY, scy);
		write_reg(REG_SCX, scx);
		write_reg(REG_BGP, bgp);
		write_reg(REG_LCDC, lcdc);
		line_pix = 0;
		for (int d = 0; d < FRAME_DOTS; d++) begin
			h = d % LINE_DOTS;
			v = d / LINE_DOTS;
			if (lcd_clkena) begin
				x = h - PIX_FIRST;
				if (v >= VIS_LINES || x < 0 || x >= PIX_LINE)
					report_failure($sformatf(
						"lcd_clkena high outside the pixel window, line %0d dot %0d", v, h));
				else
					check_shade($sformatf("pixel %0d,%0d", x, v),
						model_shade(x, v, scy, scx, bgp, lcdc), lcd_data);
				line_pix++;
			end
			if (h == LINE_DOTS - 1) begin
				check_count($sformatf("pixels on line %0d", v),
					(v < VIS_LINES) ? PIX_LINE : 0, line_pix);
				line_pix = 0;
			end
			@(negedge clk_reg);
		end
		end_test();
	endtask

	// --------------------
	// main sequence
	// --------------------

	initial begin
		reset       = 1'b1;
		cpu_sel_reg = 1'b0;
		cpu_wr      = 1'b0;
		cpu_addr    = 8'h00;
		cpu_di      = 8'h00;
		vram_data   = 8'h00;
		for (int a = 0; a < 8192; a++)
			vram_mem[a] = rand_byte();
		repeat (3) @(posedge clk_reg);
		@(negedge clk_reg);
		reset = 1'b0;

		reg_readback();
		lcd_off_outputs();
		mode_schedule();
		irq_counts();
		irq_counts();
		pixel_frame();
		pixel_frame();

		$display("tests %0d, failed %0d, checks %0d, errors %0d",
			tests_run, tests_failed, checks_total, errors_total);
		if (errors_total == 0)
			$display("Done: no errors");
		else
			$display("Done: errors found");
		$finish;
	end

endmodule

/* filelist.f */
+incdir+testbench
src/ppu_pkg.sv
src/ppu_cfg_if.sv
src/ppu_regs.sv
src/lcd_timing.sv
src/bg_fetcher.sv
src/ppu_top.sv
testbench/tb_ppu.sv

/* Bender.yml */
package:
  name: gb_bg_ppu

sources:
  # synthesizable background ppu
  - files:
      - src/ppu_pkg.sv
      - src/ppu_cfg_if.sv
      - src/ppu_regs.sv
      - src/lcd_timing.sv
      - src/bg_fetcher.sv
      - src/ppu_top.sv

  # simulation only
  - target: test
    include_dirs:
      - testbench
    files:
      - testbench/tb_ppu.sv
